// File: rtl/riscv_pkg.sv
package riscv_pkg;

	// Datapath and register index widths
	localparam int xlen       = 32;
	localparam int reg_addr_w = 5;

	// Major opcodes of the supported subset
	localparam logic [6:0] opc_op     = 7'b0110011;
	localparam logic [6:0] opc_op_imm = 7'b0010011;
	localparam logic [6:0] opc_lui    = 7'b0110111;
	localparam logic [6:0] opc_load   = 7'b0000011;
	localparam logic [6:0] opc_store  = 7'b0100011;
	localparam logic [6:0] opc_branch = 7'b1100011;

	// ADDI x0, x0, 0 used as the pipeline bubble
	localparam logic [31:0] nop_instr = 32'h0000_0013;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_slt,
		// Operand B straight through, for LUI
		alu_pass_b
	} alu_op_t;

	// Operand source for the execute stage
	typedef enum logic [1:0] {
		fwd_reg,
		fwd_from_mem,
		fwd_from_wb
	} fwd_sel_t;

	// Instruction formats, msb first
	typedef struct packed {
		logic [6:0]            funct7;
		logic [reg_addr_w-1:0] rs2;
		logic [reg_addr_w-1:0] rs1;
		logic [2:0]            funct3;
		logic [reg_addr_w-1:0] rd;
		logic [6:0]            opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0]           imm_11_0;
		logic [reg_addr_w-1:0] rs1;
		logic [2:0]            funct3;
		logic [reg_addr_w-1:0] rd;
		logic [6:0]            opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0]            imm_11_5;
		logic [reg_addr_w-1:0] rs2;
		logic [reg_addr_w-1:0] rs1;
		logic [2:0]            funct3;
		logic [4:0]            imm_4_0;
		logic [6:0]            opcode;
	} s_fmt_t;

	typedef struct packed {
		logic                  imm_12;
		logic [5:0]            imm_10_5;
		logic [reg_addr_w-1:0] rs2;
		logic [reg_addr_w-1:0] rs1;
		logic [2:0]            funct3;
		logic [3:0]            imm_4_1;
		logic                  imm_11;
		logic [6:0]            opcode;
	} b_fmt_t;

	typedef struct packed {
		logic [19:0]           imm_31_12;
		logic [reg_addr_w-1:0] rd;
		logic [6:0]            opcode;
	} u_fmt_t;

	// One instruction word, read through whichever format applies
	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		s_fmt_t s;
		b_fmt_t b;
		u_fmt_t u;
	} instr_t;

endpackage

// File: rtl/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage import riscv_pkg::*; (
	input  logic            CLK,
	input  logic            rst,
	input  logic            en,
	input  logic            stall,
	input  logic            redirect,
	input  logic [xlen-1:0] redirect_pc,
	output logic [xlen-1:0] pc
);

	// Redirect wins over a load-use hold
	always_ff @(posedge CLK) begin
		if (rst) begin
			pc <= '0;
		end else if (en) begin
			if (redirect) begin
				pc <= redirect_pc;
			end else if (!stall) begin
				pc <= pc + xlen'(4);
			end
		end
	end

	// Branch targets come from the execute stage adder
	a_pc_aligned: assert property (
		@(posedge CLK) disable iff (rst)
		pc[1:0] == 2'b00
	) else $error("fetch_stage: pc %h not word aligned", pc);

endmodule

// File: rtl/control_unit.sv
`timescale 1ns/1ps

module control_unit import riscv_pkg::*; (
	input  instr_t                instr,
	output logic [reg_addr_w-1:0] rs1,
	output logic [reg_addr_w-1:0] rs2,
	output logic [reg_addr_w-1:0] rd,
	output logic [xlen-1:0]       imm,
	output alu_op_t               alu_op,
	output logic                  use_imm,
	output logic                  reg_write,
	output logic                  mem_read,
	output logic                  mem_write,
	output logic                  is_branch,
	output logic                  branch_ne,
	output logic                  illegal
);

	always_comb begin
		// Register fields sit at the same bits in every format
		rs1       = instr.r.rs1;
		rs2       = instr.r.rs2;
		rd        = instr.r.rd;
		imm       = '0;
		alu_op    = alu_add;
		use_imm   = 1'b0;
		reg_write = 1'b0;
		mem_read  = 1'b0;
		mem_write = 1'b0;
		is_branch = 1'b0;
		branch_ne = 1'b0;
		illegal   = 1'b0;
		case (instr.r.opcode)
			opc_op: begin
				reg_write = 1'b1;
				case (instr.r.funct3)
					3'b000: alu_op = instr.r.funct7[5] ? alu_sub : alu_add;
					3'b010: alu_op = alu_slt;
					3'b100: alu_op = alu_xor;
					3'b110: alu_op = alu_or;
					3'b111: alu_op = alu_and;
					default: illegal = 1'b1;
				endcase
			end
			opc_op_imm: begin
				// ADDI only
				rs2       = '0;
				imm       = {{20{instr.i.imm_11_0[11]}}, instr.i.imm_11_0};
				use_imm   = 1'b1;
				reg_write = 1'b1;
				illegal   = instr.i.funct3 != 3'b000;
			end
			opc_lui: begin
				rs1       = '0;
				rs2       = '0;
				imm       = {instr.u.imm_31_12, 12'h000};
				alu_op    = alu_pass_b;
				use_imm   = 1'b1;
				reg_write = 1'b1;
			end
			opc_load: begin
				// LW, address is rs1 plus I immediate
				rs2       = '0;
				imm       = {{20{instr.i.imm_11_0[11]}}, instr.i.imm_11_0};
				use_imm   = 1'b1;
				reg_write = 1'b1;
				mem_read  = 1'b1;
				illegal   = instr.i.funct3 != 3'b010;
			end
			opc_store: begin
				rd        = '0;
				imm       = {{20{instr.s.imm_11_5[6]}}, instr.s.imm_11_5, instr.s.imm_4_0};
				use_imm   = 1'b1;
				mem_write = 1'b1;
				illegal   = instr.s.funct3 != 3'b010;
			end
			opc_branch: begin
				// BEQ is funct3 000, BNE is 001
				rd        = '0;
				imm       = {{19{instr.b.imm_12}}, instr.b.imm_12, instr.b.imm_11,
					instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};
				is_branch = 1'b1;
				branch_ne = instr.b.funct3[0];
				illegal   = instr.b.funct3[2:1] != 2'b00;
			end
			default: illegal = 1'b1;
		endcase
		// Anything unsupported leaves as a bubble
		if (illegal) begin
			rs1       = '0;
			rs2       = '0;
			rd        = '0;
			use_imm   = 1'b0;
			reg_write = 1'b0;
			mem_read  = 1'b0;
			mem_write = 1'b0;
			is_branch = 1'b0;
			branch_ne = 1'b0;
		end
	end

endmodule

// File: rtl/register_file.sv
`timescale 1ns/1ps

module register_file import riscv_pkg::*; (
	input  logic                  CLK,
	input  logic                  rst,
	input  logic [reg_addr_w-1:0] ra1,
	input  logic [reg_addr_w-1:0] ra2,
	output logic [xlen-1:0]       rd1,
	output logic [xlen-1:0]       rd2,
	input  logic                  we,
	input  logic [reg_addr_w-1:0] wa,
	input  logic [xlen-1:0]       wd
);

	logic [xlen-1:0] regs [2**reg_addr_w];

	// x0 reads zero, same-cycle write passes straight through
	function automatic logic [xlen-1:0] read_port(
		input logic [reg_addr_w-1:0] ra,
		input logic                  w_en,
		input logic [reg_addr_w-1:0] w_addr,
		input logic [xlen-1:0]       w_data,
		input logic [xlen-1:0]       stored
	);
		if (ra == '0) begin
			return '0;
		end
		if (w_en && w_addr == ra) begin
			return w_data;
		end
		return stored;
	endfunction

	always_ff @(posedge CLK) begin
		if (rst) begin
			for (int k = 0; k < 2**reg_addr_w; k++) begin
				regs[k] <= '0;
			end
		end else if (we && wa != '0) begin
			regs[wa] <= wd;
		end
	end

	always_comb begin
		rd1 = read_port(ra1, we, wa, wd, regs[ra1]);
		rd2 = read_port(ra2, we, wa, wd, regs[ra2]);
	end

endmodule

// File: rtl/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit import riscv_pkg::*; (
	input  logic                  ex_mem_read,
	input  logic [reg_addr_w-1:0] ex_rd,
	input  logic [reg_addr_w-1:0] dec_rs1,
	input  logic [reg_addr_w-1:0] dec_rs2,
	input  logic                  branch_taken,
	output logic                  stall_if,
	output logic                  flush_dec_ex,
	output logic                  flush_if_dec
);

	logic load_use;

	// Load result arrives too late for the next instruction's EX
	assign load_use = ex_mem_read && ex_rd != '0
		&& (ex_rd == dec_rs1 || ex_rd == dec_rs2);

	// Taken branch squashes both younger stages and overrides the hold
	assign stall_if     = load_use && !branch_taken;
	assign flush_if_dec = branch_taken;
	assign flush_dec_ex = load_use || branch_taken;

	// A branch in EX is never also the load that would cause a hold
	always_comb begin
		a_no_stall_on_branch: assert final (!(ex_mem_read && branch_taken))
			else $error("hazard_unit: load and taken branch in EX together");
	end

endmodule

// File: rtl/forwarding_unit.sv
`timescale 1ns/1ps

module forwarding_unit import riscv_pkg::*; (
	input  logic [reg_addr_w-1:0] ex_rs1,
	input  logic [reg_addr_w-1:0] ex_rs2,
	input  logic [reg_addr_w-1:0] mem_rd,
	input  logic                  mem_reg_write,
	input  logic [reg_addr_w-1:0] wb_rd,
	input  logic                  wb_reg_write,
	output fwd_sel_t              fwd_a,
	output fwd_sel_t              fwd_b
);

	// Youngest producer wins, x0 is never bypassed
	function automatic fwd_sel_t pick(
		input logic [reg_addr_w-1:0] src,
		input logic [reg_addr_w-1:0] m_rd,
		input logic                  m_we,
		input logic [reg_addr_w-1:0] w_rd,
		input logic                  w_we
	);
		if (src == '0) begin
			return fwd_reg;
		end
		if (m_we && m_rd == src) begin
			return fwd_from_mem;
		end
		if (w_we && w_rd == src) begin
			return fwd_from_wb;
		end
		return fwd_reg;
	endfunction

	assign fwd_a = pick(ex_rs1, mem_rd, mem_reg_write, wb_rd, wb_reg_write);
	assign fwd_b = pick(ex_rs2, mem_rd, mem_reg_write, wb_rd, wb_reg_write);

endmodule

// File: rtl/execute_stage.sv
`timescale 1ns/1ps

module execute_stage import riscv_pkg::*; (
	input  logic [xlen-1:0] pc,
	input  logic [xlen-1:0] imm,
	input  logic [xlen-1:0] rs1_val,
	input  logic [xlen-1:0] rs2_val,
	input  fwd_sel_t        fwd_a,
	input  fwd_sel_t        fwd_b,
	input  logic [xlen-1:0] mem_result,
	input  logic [xlen-1:0] wb_result,
	input  alu_op_t         alu_op,
	input  logic            use_imm,
	input  logic            is_branch,
	input  logic            branch_ne,
	output logic [xlen-1:0] alu_result,
	output logic [xlen-1:0] store_data,
	output logic            branch_taken,
	output logic [xlen-1:0] branch_target
);

	logic [xlen-1:0] op_a;
	logic [xlen-1:0] op_b;
	logic [xlen-1:0] src_b;

	function automatic logic [xlen-1:0] bypass(
		input fwd_sel_t        sel,
		input logic [xlen-1:0] reg_val,
		input logic [xlen-1:0] from_mem,
		input logic [xlen-1:0] from_wb
	);
		case (sel)
			fwd_from_mem: return from_mem;
			fwd_from_wb:  return from_wb;
			default:      return reg_val;
		endcase
	endfunction

	// Forwarded operands, B also feeds the store and the compare
	assign op_a       = bypass(fwd_a, rs1_val, mem_result, wb_result);
	assign src_b      = bypass(fwd_b, rs2_val, mem_result, wb_result);
	assign op_b       = use_imm ? imm : src_b;
	assign store_data = src_b;

	always_comb begin
		case (alu_op)
			alu_sub:    alu_result = op_a - op_b;
			alu_and:    alu_result = op_a & op_b;
			alu_or:     alu_result = op_a | op_b;
			alu_xor:    alu_result = op_a ^ op_b;
			alu_slt:    alu_result = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
			alu_pass_b: alu_result = op_b;
			default:    alu_result = op_a + op_b;
		endcase
	end

	// BEQ on equal, BNE on not equal
	assign branch_taken  = is_branch && ((op_a == src_b) != branch_ne);
	assign branch_target = pc + imm;

endmodule

// File: rtl/riscv_core.sv
`timescale 1ns/1ps

module riscv_core import riscv_pkg::*; (
	input  logic                  CLK,
	input  logic                  rst,
	input  logic                  en,
	output logic [xlen-1:0]       instr_addr,
	input  logic [xlen-1:0]       instr_rdata,
	output logic                  data_req,
	output logic                  data_we,
	output logic [xlen-1:0]       data_addr,
	output logic [xlen-1:0]       data_wdata,
	input  logic [xlen-1:0]       data_rdata,
	output logic                  retire_valid,
	output logic [reg_addr_w-1:0] retire_rd,
	output logic [xlen-1:0]       retire_data
);

	// Hazard and branch
	logic            stall_if;
	logic            flush_if_dec;
	logic            flush_dec_ex;
	logic            branch_taken;
	logic [xlen-1:0] branch_target;
	logic [xlen-1:0] pc;

	// IF/DEC
	logic [xlen-1:0] if_dec_pc;
	instr_t          if_dec_instr;

	// Decode outputs
	logic [reg_addr_w-1:0] dec_rs1;
	logic [reg_addr_w-1:0] dec_rs2;
	logic [reg_addr_w-1:0] dec_rd;
	logic [xlen-1:0]       dec_imm;
	logic [xlen-1:0]       dec_rs1_val;
	logic [xlen-1:0]       dec_rs2_val;
	alu_op_t               dec_alu_op;
	logic                  dec_use_imm;
	logic                  dec_reg_write;
	logic                  dec_mem_read;
	logic                  dec_mem_write;
	logic                  dec_is_branch;
	logic                  dec_branch_ne;
	logic                  dec_illegal;

	// DEC/EX
	logic [xlen-1:0]       ex_pc;
	logic [xlen-1:0]       ex_imm;
	logic [xlen-1:0]       ex_rs1_val;
	logic [xlen-1:0]       ex_rs2_val;
	logic [reg_addr_w-1:0] ex_rs1;
	logic [reg_addr_w-1:0] ex_rs2;
	logic [reg_addr_w-1:0] ex_rd;
	alu_op_t               ex_alu_op;
	logic                  ex_use_imm;
	logic                  ex_reg_write;
	logic                  ex_mem_read;
	logic                  ex_mem_write;
	logic                  ex_is_branch;
	logic                  ex_branch_ne;
	fwd_sel_t              fwd_a;
	fwd_sel_t              fwd_b;
	logic [xlen-1:0]       ex_alu_result;
	logic [xlen-1:0]       ex_store_data;

	// EX/MEM
	logic [xlen-1:0]       mem_alu_result;
	logic [xlen-1:0]       mem_store_data;
	logic [reg_addr_w-1:0] mem_rd;
	logic                  mem_reg_write;
	logic                  mem_mem_read;
	logic                  mem_mem_write;
	logic [xlen-1:0]       mem_value;

	// MEM/WB
	logic [xlen-1:0]       wb_value;
	logic [reg_addr_w-1:0] wb_rd;
	logic                  wb_reg_write;

	hazard_unit u_hazard (
		.ex_mem_read  (ex_mem_read),
		.ex_rd        (ex_rd),
		.dec_rs1      (dec_rs1),
		.dec_rs2      (dec_rs2),
		.branch_taken (branch_taken),
		.stall_if     (stall_if),
		.flush_dec_ex (flush_dec_ex),
		.flush_if_dec (flush_if_dec)
	);

	fetch_stage u_fetch (
		.CLK         (CLK),
		.rst         (rst),
		.en          (en),
		.stall       (stall_if),
		.redirect    (branch_taken),
		.redirect_pc (branch_target),
		.pc          (pc)
	);

	assign instr_addr = pc;

	// Flushed fetch becomes a NOP, stall holds the entry
	always_ff @(posedge CLK) begin
		if (rst) begin
			if_dec_instr <= nop_instr;
		end else if (en) begin
			if (flush_if_dec) begin
				if_dec_instr <= nop_instr;
			end else if (!stall_if) begin
				if_dec_instr <= instr_rdata;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (en && !stall_if) begin
			if_dec_pc <= pc;
		end
	end

	control_unit u_control (
		.instr     (if_dec_instr),
		.rs1       (dec_rs1),
		.rs2       (dec_rs2),
		.rd        (dec_rd),
		.imm       (dec_imm),
		.alu_op    (dec_alu_op),
		.use_imm   (dec_use_imm),
		.reg_write (dec_reg_write),
		.mem_read  (dec_mem_read),
		.mem_write (dec_mem_write),
		.is_branch (dec_is_branch),
		.branch_ne (dec_branch_ne),
		.illegal   (dec_illegal)
	);

	// Write port from writeback, frozen with the pipeline
	register_file u_regs (
		.CLK (CLK),
		.rst (rst),
		.ra1 (dec_rs1),
		.ra2 (dec_rs2),
		.rd1 (dec_rs1_val),
		.rd2 (dec_rs2_val),
		.we  (en && wb_reg_write),
		.wa  (wb_rd),
		.wd  (wb_value)
	);

	// Bubble on load-use hold or branch squash
	always_ff @(posedge CLK) begin
		if (rst) begin
			ex_reg_write <= 1'b0;
			ex_mem_read  <= 1'b0;
			ex_mem_write <= 1'b0;
			ex_is_branch <= 1'b0;
		end else if (en) begin
			ex_reg_write <= dec_reg_write && !flush_dec_ex;
			ex_mem_read  <= dec_mem_read && !flush_dec_ex;
			ex_mem_write <= dec_mem_write && !flush_dec_ex;
			ex_is_branch <= dec_is_branch && !flush_dec_ex;
		end
	end

	always_ff @(posedge CLK) begin
		if (en) begin
			ex_pc        <= if_dec_pc;
			ex_imm       <= dec_imm;
			ex_rs1_val   <= dec_rs1_val;
			ex_rs2_val   <= dec_rs2_val;
			ex_rs1       <= dec_rs1;
			ex_rs2       <= dec_rs2;
			ex_rd        <= dec_rd;
			ex_alu_op    <= dec_alu_op;
			ex_use_imm   <= dec_use_imm;
			ex_branch_ne <= dec_branch_ne;
		end
	end

	forwarding_unit u_forward (
		.ex_rs1        (ex_rs1),
		.ex_rs2        (ex_rs2),
		.mem_rd        (mem_rd),
		.mem_reg_write (mem_reg_write),
		.wb_rd         (wb_rd),
		.wb_reg_write  (wb_reg_write),
		.fwd_a         (fwd_a),
		.fwd_b         (fwd_b)
	);

	execute_stage u_execute (
		.pc            (ex_pc),
		.imm           (ex_imm),
		.rs1_val       (ex_rs1_val),
		.rs2_val       (ex_rs2_val),
		.fwd_a         (fwd_a),
		.fwd_b         (fwd_b),
		.mem_result    (mem_value),
		.wb_result     (wb_value),
		.alu_op        (ex_alu_op),
		.use_imm       (ex_use_imm),
		.is_branch     (ex_is_branch),
		.branch_ne     (ex_branch_ne),
		.alu_result    (ex_alu_result),
		.store_data    (ex_store_data),
		.branch_taken  (branch_taken),
		.branch_target (branch_target)
	);

	always_ff @(posedge CLK) begin
		if (rst) begin
			mem_reg_write <= 1'b0;
			mem_mem_read  <= 1'b0;
			mem_mem_write <= 1'b0;
		end else if (en) begin
			mem_reg_write <= ex_reg_write;
			mem_mem_read  <= ex_mem_read;
			mem_mem_write <= ex_mem_write;
		end
	end

	always_ff @(posedge CLK) begin
		if (en) begin
			mem_alu_result <= ex_alu_result;
			mem_store_data <= ex_store_data;
			mem_rd         <= ex_rd;
		end
	end

	// Single-cycle strobe, word address only
	assign data_req   = en && (mem_mem_read || mem_mem_write);
	assign data_we    = en && mem_mem_write;
	assign data_addr  = {mem_alu_result[xlen-1:2], 2'b00};
	assign data_wdata = mem_store_data;

	// Load data is valid in this same cycle
	assign mem_value = mem_mem_read ? data_rdata : mem_alu_result;

	always_ff @(posedge CLK) begin
		if (rst) begin
			wb_reg_write <= 1'b0;
		end else if (en) begin
			wb_reg_write <= mem_reg_write;
		end
	end

	always_ff @(posedge CLK) begin
		if (en) begin
			wb_value <= mem_value;
			wb_rd    <= mem_rd;
		end
	end

	// Writes to x0 never show up as retirements
	assign retire_valid = en && wb_reg_write && wb_rd != '0;
	assign retire_rd    = wb_rd;
	assign retire_data  = wb_value;

	// Entry in decode is real unless a taken branch or hold discards it
	a_no_illegal: assert property (
		@(posedge CLK) disable iff (rst)
		en && !flush_dec_ex |-> !dec_illegal
	) else $error("riscv_core: illegal instruction %h at pc %h", if_dec_instr, if_dec_pc);

endmodule

// File: tests/tb_riscv_model.svh
`ifndef TB_RISCV_MODEL_SVH
`define TB_RISCV_MODEL_SVH

// Program image and expected retirements {rd, value} and stores {addr, data}
logic [31:0] prog [$];
logic [36:0] exp_ret [$];
logic [63:0] exp_st [$];
logic [31:0] rng_state;

// xorshift32 on the shared state
function automatic logic [31:0] next_rand();
	rng_state ^= rng_state << 13;
	rng_state ^= rng_state >> 17;
	rng_state ^= rng_state << 5;
	return rng_state;
endfunction

// Initial data memory word for one word address
function automatic logic [31:0] fill_word(input int idx);
	return (idx * 32'h9e37_79b9) ^ 32'h5a3c_c3a5;
endfunction

// R-type with op 0..5 as ADD SUB AND OR XOR SLT
function automatic logic [31:0] alu_r(
	input int         op,
	input logic [4:0] rd,
	input logic [4:0] rs1,
	input logic [4:0] rs2
);
	logic [2:0] f3;
	logic [6:0] f7;
	f7 = (op == 1) ? 7'h20 : 7'h00;
	case (op)
		2: f3 = 3'h7;
		3: f3 = 3'h6;
		4: f3 = 3'h4;
		5: f3 = 3'h2;
		default: f3 = 3'h0;
	endcase
	return {f7, rs2, rs1, f3, rd, 7'h33};
endfunction

function automatic logic [31:0] addi(
	input logic [4:0]  rd,
	input logic [4:0]  rs1,
	input logic [11:0] imm
);
	return {imm, rs1, 3'h0, rd, 7'h13};
endfunction

function automatic logic [31:0] lui(input logic [4:0] rd, input logic [19:0] imm);
	return {imm, rd, 7'h37};
endfunction

function automatic logic [31:0] lw(
	input logic [4:0]  rd,
	input logic [4:0]  rs1,
	input logic [11:0] imm
);
	return {imm, rs1, 3'h2, rd, 7'h03};
endfunction

function automatic logic [31:0] sw(
	input logic [4:0]  rs2,
	input logic [4:0]  rs1,
	input logic [11:0] imm
);
	return {imm[11:5], rs2, rs1, 3'h2, imm[4:0], 7'h23};
endfunction

// BEQ for ne low and BNE for ne high with a byte offset
function automatic logic [31:0] br(
	input logic        ne,
	input logic [4:0]  rs1,
	input logic [4:0]  rs2,
	input logic [12:0] imm
);
	return {imm[12], imm[10:5], rs2, rs1, 2'b00, ne, imm[4:1], imm[11], 7'h63};
endfunction

// Random ALU ops on x0..x15 including x0
task automatic emit_alu(input int count);
	logic [31:0] r;
	for (int k = 0; k < count; k++) begin
		r = next_rand();
		case (r[31:29])
			3'd0: prog.push_back(addi({1'b0, r[3:0]}, {1'b0, r[7:4]}, r[23:12]));
			3'd1: prog.push_back(lui({1'b0, r[3:0]}, r[27:8]));
			default: prog.push_back(alu_r(int'(r[31:29]) - 2, {1'b0, r[3:0]},
				{1'b0, r[7:4]}, {1'b0, r[11:8]}));
		endcase
	end
endtask

// Stores and loads in the first 64 words off base x0
task automatic emit_mem(input int count);
	logic [31:0] r;
	for (int k = 0; k < count; k++) begin
		r = next_rand();
		if (r[31]) begin
			prog.push_back(sw({1'b0, r[3:0]}, 5'd0, {4'h0, r[13:8], 2'b00}));
		end else begin
			prog.push_back(lw({1'b0, r[3:0]}, 5'd0, {4'h0, r[13:8], 2'b00}));
			// Consumer right behind the load
			if (r[30]) begin
				prog.push_back(alu_r(0, {1'b0, r[19:16]}, {1'b0, r[3:0]}, {1'b0, r[23:20]}));
			end
		end
	end
endtask

// Forward branch over one or two ALU ops
task automatic emit_branch();
	logic [31:0] r;
	int          skip;
	r = next_rand();
	skip = 1 + r[8];
	prog.push_back(br(r[9], {1'b0, r[3:0]}, {1'b0, r[7:4]}, 13'(4 * (skip + 1))));
	emit_alu(skip);
endtask

task automatic build_program();
	prog.delete();
	// Dependent chain through both bypass paths
	prog.push_back(addi(5'd1, 5'd0, 12'd5));
	prog.push_back(addi(5'd2, 5'd1, 12'hffd));
	prog.push_back(alu_r(0, 5'd3, 5'd1, 5'd2));
	prog.push_back(alu_r(1, 5'd4, 5'd3, 5'd1));
	prog.push_back(lui(5'd5, 20'habcde));
	prog.push_back(alu_r(4, 5'd6, 5'd5, 5'd4));
	prog.push_back(alu_r(5, 5'd7, 5'd6, 5'd4));
	prog.push_back(alu_r(2, 5'd8, 5'd6, 5'd5));
	prog.push_back(alu_r(3, 5'd9, 5'd8, 5'd1));
	// x0 as destination and as source
	prog.push_back(addi(5'd0, 5'd1, 12'd7));
	prog.push_back(alu_r(0, 5'd10, 5'd0, 5'd1));
	// Store and read back with each load used at once
	prog.push_back(addi(5'd20, 5'd0, 12'd64));
	prog.push_back(sw(5'd3, 5'd20, 12'd0));
	prog.push_back(lw(5'd11, 5'd20, 12'd0));
	prog.push_back(alu_r(0, 5'd12, 5'd11, 5'd11));
	prog.push_back(sw(5'd12, 5'd20, 12'd4));
	prog.push_back(lw(5'd13, 5'd20, 12'd4));
	prog.push_back(sw(5'd13, 5'd0, 12'd8));
	// Taken BEQ then BNE not taken then BNE taken over two
	prog.push_back(br(1'b0, 5'd1, 5'd1, 13'd8));
	prog.push_back(addi(5'd14, 5'd0, 12'd1));
	prog.push_back(br(1'b1, 5'd1, 5'd1, 13'd8));
	prog.push_back(addi(5'd14, 5'd0, 12'd2));
	prog.push_back(br(1'b1, 5'd1, 5'd2, 13'd12));
	prog.push_back(addi(5'd15, 5'd0, 12'd3));
	prog.push_back(addi(5'd15, 5'd0, 12'd4));
	// Backward loop of three passes
	prog.push_back(addi(5'd15, 5'd0, 12'd3));
	prog.push_back(addi(5'd15, 5'd15, 12'hfff));
	prog.push_back(br(1'b1, 5'd15, 5'd0, 13'h1ffc));
	// Load feeding a branch compare
	prog.push_back(lw(5'd14, 5'd20, 12'd0));
	prog.push_back(br(1'b0, 5'd14, 5'd3, 13'd8));
	prog.push_back(addi(5'd14, 5'd0, 12'd9));
	for (int k = 0; k < 4; k++) begin
		emit_alu(10);
		emit_mem(5);
		emit_branch();
		emit_alu(3);
		emit_branch();
	end
	prog.push_back(br(1'b0, 5'd0, 5'd0, 13'd0));
endtask

// ISA-level run of prog filling exp_ret and exp_st
function automatic void run_model();
	logic [31:0] x [32];
	logic [31:0] mem [256];
	logic [31:0] pc;
	logic [31:0] next_pc;
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] val;
	logic [31:0] addr;
	logic        wr;
	instr_t      w;
	int          steps;
	exp_ret.delete();
	exp_st.delete();
	for (int k = 0; k < 32; k++) begin
		x[k] = '0;
	end
	for (int k = 0; k < 256; k++) begin
		mem[k] = fill_word(k);
	end
	pc = '0;
	for (steps = 0; steps < 4000; steps++) begin
		if (pc[31:2] >= prog.size()) begin
			$display("Model left the program at pc %h", pc);
			break;
		end
		w = prog[pc[31:2]];
		a = x[w.r.rs1];
		b = x[w.r.rs2];
		val = '0;
		wr = 1'b0;
		next_pc = pc + 4;
		case (w.r.opcode)
			7'h33: begin
				wr = 1'b1;
				case (w.r.funct3)
					3'h0: val = w.r.funct7[5] ? a - b : a + b;
					3'h2: val = {31'b0, $signed(a) < $signed(b)};
					3'h4: val = a ^ b;
					3'h6: val = a | b;
					default: val = a & b;
				endcase
			end
			7'h13: begin
				wr = 1'b1;
				val = a + {{20{w.i.imm_11_0[11]}}, w.i.imm_11_0};
			end
			7'h37: begin
				wr = 1'b1;
				val = {w.u.imm_31_12, 12'h000};
			end
			7'h03: begin
				wr = 1'b1;
				addr = a + {{20{w.i.imm_11_0[11]}}, w.i.imm_11_0};
				val = mem[addr[9:2]];
			end
			7'h23: begin
				addr = a + {{20{w.s.imm_11_5[6]}}, w.s.imm_11_5, w.s.imm_4_0};
				addr[1:0] = 2'b00;
				mem[addr[9:2]] = b;
				exp_st.push_back({addr, b});
			end
			default: begin
				// Branch taken on equal for BEQ and on unequal for BNE
				if ((a == b) != w.b.funct3[0]) begin
					next_pc = pc + {{19{w.b.imm_12}}, w.b.imm_12, w.b.imm_11,
						w.b.imm_10_5, w.b.imm_4_1, 1'b0};
				end
			end
		endcase
		if (wr && w.r.rd != 5'd0) begin
			x[w.r.rd] = val;
			exp_ret.push_back({w.r.rd, val});
		end
		// Self-loop marks the end
		if (next_pc == pc) begin
			break;
		end
		pc = next_pc;
	end
	if (steps >= 4000) begin
		$display("Model did not reach the closing self-loop");
	end
endfunction

`endif

// File: tests/tb_riscv_core.sv
`timescale 1ns/1ps

module tb_riscv_core import riscv_pkg::*;;

	logic                  CLK;
	logic                  rst;
	logic                  en;
	logic [xlen-1:0]       instr_addr;
	logic [xlen-1:0]       instr_rdata;
	logic                  data_req;
	logic                  data_we;
	logic [xlen-1:0]       data_addr;
	logic [xlen-1:0]       data_wdata;
	logic [xlen-1:0]       data_rdata;
	logic                  retire_valid;
	logic [reg_addr_w-1:0] retire_rd;
	logic [xlen-1:0]       retire_data;

	logic [31:0] imem [256];
	logic [31:0] dmem [256];
	int          prog_len;
	logic        rst_q;
	int          mismatch_count;
	int          error_count;

	`include "tb_riscv_model.svh"

	riscv_core DUT (
		.CLK          (CLK),
		.rst          (rst),
		.en           (en),
		.instr_addr   (instr_addr),
		.instr_rdata  (instr_rdata),
		.data_req     (data_req),
		.data_we      (data_we),
		.data_addr    (data_addr),
		.data_wdata   (data_wdata),
		.data_rdata   (data_rdata),
		.retire_valid (retire_valid),
		.retire_rd    (retire_rd),
		.retire_data  (retire_data)
	);

	initial begin
		CLK = 1'b0;
		forever begin
			#10 CLK = ~CLK;
		end
	end

	// Words past the program read as NOPs
	assign instr_rdata = (instr_addr[31:2] < prog_len) ? imem[instr_addr[9:2]] : 32'h0000_0013;

	// Combinational read answered only on a strobe
	assign data_rdata = data_req ? dmem[data_addr[9:2]] : 'x;

	// Write lands at the end of the strobed cycle
	always @(posedge CLK) begin
		if (data_req && data_we) begin
			dmem[data_addr[9:2]] <= data_wdata;
		end
	end

	// Reset seen by the core at an edge
	always @(posedge CLK) begin
		rst_q <= rst;
	end

	task automatic check_retire();
		logic [36:0] e;
		assert (exp_ret.size() != 0) else begin
			$display("Retirement of x%0d = %h with none expected", retire_rd, retire_data);
			error_count++;
		end
		if (exp_ret.size() != 0) begin
			e = exp_ret.pop_front();
			assert (retire_rd == e[36:32]) else begin
				$display("MISMATCH retire_rd: got %h expected %h", retire_rd, e[36:32]);
				mismatch_count++;
			end
			assert (retire_data == e[31:0]) else begin
				$display("MISMATCH retire_data: got %h expected %h", retire_data, e[31:0]);
				mismatch_count++;
			end
		end
	endtask

	task automatic check_store();
		logic [63:0] e;
		assert (exp_st.size() != 0) else begin
			$display("Store to %h with none expected", data_addr);
			error_count++;
		end
		if (exp_st.size() != 0) begin
			e = exp_st.pop_front();
			assert (data_addr == e[63:32]) else begin
				$display("MISMATCH data_addr: got %h expected %h", data_addr, e[63:32]);
				mismatch_count++;
			end
			assert (data_wdata == e[31:0]) else begin
				$display("MISMATCH data_wdata: got %h expected %h", data_wdata, e[31:0]);
				mismatch_count++;
			end
		end
	endtask

	// Responses compared at the falling edge
	always @(negedge CLK) begin
		if (rst) begin
			if (rst_q) begin
				assert (!retire_valid && !data_req) else begin
					$display("retire_valid or data_req high during reset");
					error_count++;
				end
			end
		end else begin
			if (!en) begin
				assert (!retire_valid && !data_req) else begin
					$display("retire_valid or data_req high while en is low");
					error_count++;
				end
			end
			if (retire_valid) begin
				check_retire();
			end
			if (data_req && data_we) begin
				check_store();
			end
		end
	end

	// One program from reset to its closing self-loop
	task automatic run_program(input logic toggle_en);
		int cycles;
		@(posedge CLK);
		#1;
		rst = 1'b1;
		en = 1'b1;
		build_program();
		run_model();
		@(posedge CLK);
		#1;
		// Memories change only while the core is in reset
		prog_len = prog.size();
		for (int k = 0; k < prog_len; k++) begin
			imem[k] = prog[k];
		end
		for (int k = 0; k < 256; k++) begin
			dmem[k] = fill_word(k);
		end
		repeat (7) begin
			@(posedge CLK);
			#1;
		end
		rst = 1'b0;
		cycles = 0;
		while ((exp_ret.size() != 0 || exp_st.size() != 0) && cycles < 5000) begin
			@(posedge CLK);
			#1;
			// Roughly a third of the cycles frozen
			if (toggle_en) begin
				en = (next_rand() % 3) != 0;
			end
			cycles++;
		end
		en = 1'b1;
		assert (cycles < 5000) else begin
			$display("Timeout with %0d retirements and %0d stores still outstanding",
				exp_ret.size(), exp_st.size());
			error_count++;
		end
		// Self-loop must stay quiet
		repeat (24) begin
			@(posedge CLK);
		end
	endtask

	initial begin
		rst = 1'b1;
		en = 1'b1;
		prog_len = 0;
		rng_state = 32'h6eaa;
		mismatch_count = 0;
		error_count = 0;
		// Steady enable first and then a new program with en toggling
		run_program(1'b0);
		run_program(1'b1);
		$display("Done with %0d mismatches and %0d other errors", mismatch_count, error_count);
		if (mismatch_count == 0 && error_count == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

// File: sim.f
+incdir+tests
rtl/riscv_pkg.sv
rtl/fetch_stage.sv
rtl/control_unit.sv
rtl/register_file.sv
rtl/hazard_unit.sv
rtl/forwarding_unit.sv
rtl/execute_stage.sv
rtl/riscv_core.sv
tests/tb_riscv_core.sv

// File: Bender.yml
package:
  name: riscv_core

sources:
  - rtl/riscv_pkg.sv
  - rtl/fetch_stage.sv
  - rtl/control_unit.sv
  - rtl/register_file.sv
  - rtl/hazard_unit.sv
  - rtl/forwarding_unit.sv
  - rtl/execute_stage.sv
  - rtl/riscv_core.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_riscv_core.sv
